// ==== lsu_pkg.sv ====
// Shared types of the load/store unit
// Word and address widths, cache line geometry
// CPU request and load result, memory command, snoop result
// Store buffer search result

package lsu_pkg;

   // --------------------
   // Widths
   // --------------------
   typedef logic [31:0] word_t;
   // Word address, one word is the unit of access
   typedef logic [15:0] addr_t;

   // Line geometry
   localparam int LINE_WORDS = 4;
   localparam int OFFS_W     = $clog2(LINE_WORDS);

   typedef enum logic {
      OP_LOAD  = 1'b0,
      OP_STORE = 1'b1
   } lsu_op_e;

   // --------------------
   // Structs
   // --------------------
   typedef struct packed {
      lsu_op_e op;
      addr_t   addr;
      word_t   data;
   } lsu_req_t;

   typedef struct packed {
      word_t data;
      addr_t addr;
   } lsu_resp_t;

   typedef struct packed {
      logic  write;
      addr_t addr;
      word_t data;
   } mem_cmd_t;

   typedef struct packed {
      logic  hit;
      word_t data;
   } snoop_resp_t;

   // Youngest buffered store to the searched word
   typedef struct packed {
      logic  match;
      word_t data;
   } sb_search_t;

endpackage

// ==== lsu_pipe.sv ====
// Two-stage load/store pipeline
// s0 holds the request and reads the cache
// s1 checks the hit, searches the store buffer and pushes stores
// Load misses stall, wait for the drain and the refill, then replay

`timescale 1ns/1ps

module lsu_pipe
   import lsu_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_reset_n,
   // CPU side
   input  logic       i_req_valid,
   input  lsu_req_t   i_req,
   output logic       o_req_ready,
   output logic       o_resp_valid,
   output lsu_resp_t  o_resp,
   // Cache read port
   output logic       o_rd_valid,
   output addr_t      o_rd_addr,
   input  logic       i_rd_hit,
   input  word_t      i_rd_data,
   // Store buffer
   output logic       o_sb_push,
   output mem_cmd_t   o_sb_entry,
   output addr_t      o_sb_search_addr,
   input  sb_search_t i_sb_search,
   input  logic       i_sb_full,
   input  logic       i_sb_empty,
   // Miss unit
   output logic       o_miss_start,
   output addr_t      o_miss_addr,
   input  logic       i_miss_done
);

   typedef enum logic [1:0] {
      RUN,
      WAIT_DRAIN,
      WAIT_REFILL,
      REPLAY
   } pipe_state_e;

   pipe_state_e r_state;
   logic        r_s0_valid;
   logic        r_s1_valid;
   lsu_req_t    r_s0_req;
   lsu_req_t    r_s1_req;

   logic w_s1_load;
   logic w_s1_store;
   logic w_s1_miss;
   logic w_s1_stall;
   logic w_advance;

   // --------------------
   // Stage s1 decisions
   // --------------------
   assign w_s1_load  = r_s1_valid && (r_s1_req.op == OP_LOAD);
   assign w_s1_store = r_s1_valid && (r_s1_req.op == OP_STORE);
   // Buffered store wins over cache data
   assign w_s1_miss  = w_s1_load && !i_sb_search.match && !i_rd_hit;
   // Store waits in s1 for a free buffer slot
   assign w_s1_stall = w_s1_store && i_sb_full;
   assign w_advance  = (r_state == RUN) && !w_s1_miss && !w_s1_stall;

   assign o_req_ready = w_advance && !i_sb_full;

   // Replay reuses the read port for the missing load
   assign o_rd_valid = r_s0_valid || (r_state == REPLAY);
   assign o_rd_addr  = (r_state == REPLAY) ? r_s1_req.addr : r_s0_req.addr;

   assign o_sb_search_addr = r_s1_req.addr;
   assign o_sb_push        = w_s1_store && !i_sb_full;
   assign o_sb_entry       = '{write: 1'b1, addr: r_s1_req.addr, data: r_s1_req.data};

   assign o_miss_start = (r_state == WAIT_DRAIN) && i_sb_empty;
   assign o_miss_addr  = r_s1_req.addr;

   // --------------------
   // Control and FSM
   // --------------------
   always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_state      <= RUN;
         r_s0_valid   <= 1'b0;
         r_s1_valid   <= 1'b0;
         o_resp_valid <= 1'b0;
      end else begin
         o_resp_valid <= w_s1_load && !w_s1_miss;
         if (w_advance) begin
            r_s0_valid <= i_req_valid && o_req_ready;
            r_s1_valid <= r_s0_valid;
         end else if (w_s1_miss) begin
            r_s1_valid <= 1'b0;
         end else if (r_state == REPLAY) begin
            r_s1_valid <= 1'b1;
         end
         case (r_state)
            RUN:         if (w_s1_miss)   r_state <= WAIT_DRAIN;
            WAIT_DRAIN:  if (i_sb_empty)  r_state <= WAIT_REFILL;
            WAIT_REFILL: if (i_miss_done) r_state <= REPLAY;
            default:                      r_state <= RUN;
         endcase
      end
   end

   // Request and result payload
   always_ff @(posedge i_clk) begin
      if (i_req_valid && o_req_ready) begin
         r_s0_req <= i_req;
      end
      if (w_advance && r_s0_valid) begin
         r_s1_req <= r_s0_req;
      end
      o_resp.data <= i_sb_search.match ? i_sb_search.data : i_rd_data;
      o_resp.addr <= r_s1_req.addr;
   end

endmodule

// ==== lsu_dcache.sv ====
// Direct-mapped data cache
// Pipeline and snoop read ports with registered results
// Refill write port and store-update port

`timescale 1ns/1ps

module lsu_dcache
   import lsu_pkg::*;
#(
   parameter int NUM_SETS = 16
) (
   input  logic  i_clk,
   input  logic  i_reset_n,
   // Pipeline read port
   input  logic  i_rd_valid,
   input  addr_t i_rd_addr,
   output logic  o_rd_hit,
   output word_t o_rd_data,
   // Snoop read port
   input  logic  i_snp_valid,
   input  addr_t i_snp_addr,
   output logic  o_snp_hit,
   output word_t o_snp_data,
   // Refill port
   input  logic  i_refill_we,
   input  addr_t i_refill_addr,
   input  word_t i_refill_data,
   input  logic  i_refill_last,
   // Store-update port
   input  logic  i_upd_we,
   input  addr_t i_upd_addr,
   input  word_t i_upd_data
);

   localparam int IDX_W  = $clog2(NUM_SETS);
   localparam int TAG_W  = $bits(addr_t) - IDX_W - OFFS_W;
   localparam int WIDX_W = IDX_W + OFFS_W;

   logic [TAG_W-1:0]    r_tag  [NUM_SETS];
   logic [NUM_SETS-1:0] r_valid;
   word_t               r_data [NUM_SETS * LINE_WORDS];

   logic w_upd_hit;

   // --------------------
   // Address split
   // --------------------
   function automatic logic [IDX_W-1:0] set_of(addr_t a);
      return a[OFFS_W +: IDX_W];
   endfunction

   function automatic logic [TAG_W-1:0] tag_of(addr_t a);
      return a[$bits(addr_t)-1 -: TAG_W];
   endfunction

   function automatic logic [WIDX_W-1:0] word_of(addr_t a);
      return a[WIDX_W-1:0];
   endfunction

   // Line present with matching tag
   function automatic logic lookup(addr_t a);
      return r_valid[set_of(a)] && (r_tag[set_of(a)] == tag_of(a));
   endfunction

   assign w_upd_hit = i_upd_we && lookup(i_upd_addr);

   // Valid bits and hit flags
   always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_valid   <= '0;
         o_rd_hit  <= 1'b0;
         o_snp_hit <= 1'b0;
      end else begin
         o_rd_hit  <= i_rd_valid && lookup(i_rd_addr);
         o_snp_hit <= i_snp_valid && lookup(i_snp_addr);
         // Line goes invalid while refilling, valid on the last word
         if (i_refill_we) begin
            r_valid[set_of(i_refill_addr)] <= i_refill_last;
         end
      end
   end

   // Tag and data arrays
   always_ff @(posedge i_clk) begin
      if (i_refill_we) begin
         r_tag[set_of(i_refill_addr)]   <= tag_of(i_refill_addr);
         r_data[word_of(i_refill_addr)] <= i_refill_data;
      end else if (w_upd_hit) begin
         r_data[word_of(i_upd_addr)] <= i_upd_data;
      end
      o_rd_data  <= r_data[word_of(i_rd_addr)];
      o_snp_data <= r_data[word_of(i_snp_addr)];
   end

endmodule

// ==== lsu_miss_unit.sv ====
// Single-entry miss handler
// Fetches one line word by word over a four-phase read port
// Writes each word into the cache at its ack

`timescale 1ns/1ps

module lsu_miss_unit
   import lsu_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_reset_n,
   input  logic     i_start,
   input  addr_t    i_addr,
   output logic     o_done,
   // Memory client port
   output logic     o_mreq,
   output mem_cmd_t o_mcmd,
   input  logic     i_mack,
   input  word_t    i_mrdata,
   // Cache refill port
   output logic     o_refill_we,
   output addr_t    o_refill_addr,
   output word_t    o_refill_data,
   output logic     o_refill_last
);

   typedef enum logic [1:0] {
      MS_IDLE,
      MS_REQ,
      MS_ACK_LOW
   } miss_state_e;

   miss_state_e       r_state;
   logic [OFFS_W-1:0] r_word;
   addr_t             r_line;
   logic              r_done;

   addr_t w_cur_addr;
   logic  w_last;

   assign w_cur_addr = {r_line[$bits(addr_t)-1:OFFS_W], r_word};
   assign w_last     = (r_word == OFFS_W'(LINE_WORDS - 1));

   assign o_mreq = (r_state == MS_REQ);
   assign o_mcmd = '{write: 1'b0, addr: w_cur_addr, data: '0};
   assign o_done = r_done;

   // Read data is only valid while ack is high
   assign o_refill_we   = (r_state == MS_REQ) && i_mack;
   assign o_refill_addr = w_cur_addr;
   assign o_refill_data = i_mrdata;
   assign o_refill_last = w_last;

   // --------------------
   // Fetch FSM
   // --------------------
   always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_state <= MS_IDLE;
         r_word  <= '0;
         r_done  <= 1'b0;
      end else begin
         r_done <= 1'b0;
         case (r_state)
            MS_IDLE: begin
               if (i_start) begin
                  r_word  <= '0;
                  r_state <= MS_REQ;
               end
            end
            MS_REQ: begin
               if (i_mack) begin
                  r_state <= MS_ACK_LOW;
               end
            end
            default: begin
               // Next word only once ack has fallen
               if (!i_mack) begin
                  r_word  <= r_word + 1'b1;
                  r_done  <= w_last;
                  r_state <= w_last ? MS_IDLE : MS_REQ;
               end
            end
         endcase
      end
   end

   // Line base address
   always_ff @(posedge i_clk) begin
      if (i_start && (r_state == MS_IDLE)) begin
         r_line <= i_addr;
      end
   end

endmodule

// ==== lsu_store_buffer.sv ====
// Store buffer FIFO
// Youngest-match search for load forwarding
// Four-phase write drain with cache update at the ack

`timescale 1ns/1ps

module lsu_store_buffer
   import lsu_pkg::*;
#(
   parameter int SB_DEPTH = 4
) (
   input  logic       i_clk,
   input  logic       i_reset_n,
   input  logic       i_push,
   input  mem_cmd_t   i_entry,
   input  addr_t      i_search_addr,
   output sb_search_t o_search,
   output logic       o_full,
   output logic       o_empty,
   // Memory client port
   output logic       o_mreq,
   output mem_cmd_t   o_mcmd,
   input  logic       i_mack,
   // Cache update port
   output logic       o_upd_we,
   output addr_t      o_upd_addr,
   output word_t      o_upd_data
);

   localparam int PTR_W = $clog2(SB_DEPTH);
   localparam int CNT_W = $clog2(SB_DEPTH + 1);

   typedef enum logic [1:0] {
      DR_IDLE,
      DR_REQ,
      DR_ACK_LOW
   } drain_state_e;

   drain_state_e     r_state;
   mem_cmd_t         r_ent [SB_DEPTH];
   logic [PTR_W-1:0] r_wr_ptr;
   logic [PTR_W-1:0] r_rd_ptr;
   logic [CNT_W-1:0] r_count;

   logic w_pop;

   assign o_full  = (r_count == CNT_W'(SB_DEPTH));
   assign o_empty = (r_count == '0);

   // Head entry stays until ack falls
   assign w_pop  = (r_state == DR_ACK_LOW) && !i_mack;
   assign o_mreq = (r_state == DR_REQ);
   assign o_mcmd = r_ent[r_rd_ptr];

   assign o_upd_we   = (r_state == DR_REQ) && i_mack;
   assign o_upd_addr = o_mcmd.addr;
   assign o_upd_data = o_mcmd.data;

   // --------------------
   // Search
   // --------------------
   // Walk oldest to youngest so the last match wins
   always_comb begin
      logic [PTR_W-1:0] idx;
      o_search = '0;
      for (int i = 0; i < SB_DEPTH; i++) begin
         idx = r_rd_ptr + PTR_W'(i);
         if ((CNT_W'(i) < r_count) && (r_ent[idx].addr == i_search_addr)) begin
            o_search.match = 1'b1;
            o_search.data  = r_ent[idx].data;
         end
      end
   end

   // Pointers and drain FSM
   always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_state  <= DR_IDLE;
         r_wr_ptr <= '0;
         r_rd_ptr <= '0;
         r_count  <= '0;
      end else begin
         if (i_push) begin
            r_wr_ptr <= r_wr_ptr + 1'b1;
         end
         if (w_pop) begin
            r_rd_ptr <= r_rd_ptr + 1'b1;
         end
         if (i_push && !w_pop) begin
            r_count <= r_count + 1'b1;
         end else if (w_pop && !i_push) begin
            r_count <= r_count - 1'b1;
         end
         case (r_state)
            DR_IDLE:    if (!o_empty) r_state <= DR_REQ;
            DR_REQ:     if (i_mack)   r_state <= DR_ACK_LOW;
            default:    if (!i_mack)  r_state <= DR_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         r_ent[r_wr_ptr] <= i_entry;
      end
   end

endmodule

// ==== lsu_mem_arbiter.sv ====
// Two-client arbiter for four-phase memory ports
// Client 0 has fixed priority, grant held until ack falls

`timescale 1ns/1ps

module lsu_mem_arbiter
   import lsu_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_reset_n,
   // Client 0
   input  logic     i_req0,
   input  mem_cmd_t i_cmd0,
   output logic     o_ack0,
   // Client 1
   input  logic     i_req1,
   input  mem_cmd_t i_cmd1,
   output logic     o_ack1,
   // Memory port
   output logic     o_mem_req,
   output mem_cmd_t o_mem_cmd,
   input  logic     i_mem_ack
);

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_GRANT0,
      ARB_GRANT1
   } arb_state_e;

   arb_state_e r_state;

   assign o_mem_req = ((r_state == ARB_GRANT0) && i_req0) ||
                      ((r_state == ARB_GRANT1) && i_req1);
   assign o_mem_cmd = (r_state == ARB_GRANT1) ? i_cmd1 : i_cmd0;
   assign o_ack0    = (r_state == ARB_GRANT0) && i_mem_ack;
   assign o_ack1    = (r_state == ARB_GRANT1) && i_mem_ack;

   always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_state <= ARB_IDLE;
      end else begin
         case (r_state)
            ARB_IDLE: begin
               if (i_req0) begin
                  r_state <= ARB_GRANT0;
               end else if (i_req1) begin
                  r_state <= ARB_GRANT1;
               end
            end
            // Release only after the full handshake
            ARB_GRANT0: if (!i_req0 && !i_mem_ack) r_state <= ARB_IDLE;
            default:    if (!i_req1 && !i_mem_ack) r_state <= ARB_IDLE;
         endcase
      end
   end

endmodule

// ==== lsu_top.sv ====
// Load/store unit top level
// Pipeline, data cache, miss unit, store buffer and memory arbiter
// Registered snoop response valid

`timescale 1ns/1ps

module lsu_top
   import lsu_pkg::*;
#(
   parameter int NUM_SETS = 16,
   parameter int SB_DEPTH = 4
) (
   input  logic        i_clk,
   input  logic        i_reset_n,
   // CPU side
   input  logic        i_req_valid,
   input  lsu_req_t    i_req,
   output logic        o_req_ready,
   output logic        o_resp_valid,
   output lsu_resp_t   o_resp,
   // Snoop side
   input  logic        i_snoop_valid,
   input  addr_t       i_snoop_addr,
   output logic        o_snoop_resp_valid,
   output snoop_resp_t o_snoop_resp,
   // Memory side
   output logic        o_mem_req,
   output mem_cmd_t    o_mem_cmd,
   input  logic        i_mem_ack,
   input  word_t       i_mem_rdata
);

   // Cache ports
   logic       w_rd_valid;
   addr_t      w_rd_addr;
   logic       w_rd_hit;
   word_t      w_rd_data;
   logic       w_snp_hit;
   word_t      w_snp_data;
   logic       w_refill_we;
   addr_t      w_refill_addr;
   word_t      w_refill_data;
   logic       w_refill_last;
   logic       w_upd_we;
   addr_t      w_upd_addr;
   word_t      w_upd_data;
   // Store buffer and miss unit
   logic       w_sb_push;
   mem_cmd_t   w_sb_entry;
   addr_t      w_sb_search_addr;
   sb_search_t w_sb_search;
   logic       w_sb_full;
   logic       w_sb_empty;
   logic       w_miss_start;
   addr_t      w_miss_addr;
   logic       w_miss_done;
   // Arbiter clients
   logic       w_miss_mreq;
   mem_cmd_t   w_miss_mcmd;
   logic       w_miss_mack;
   logic       w_sb_mreq;
   mem_cmd_t   w_sb_mcmd;
   logic       w_sb_mack;

   lsu_pipe u_pipe (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_req_valid      (i_req_valid),
      .i_req            (i_req),
      .o_req_ready      (o_req_ready),
      .o_resp_valid     (o_resp_valid),
      .o_resp           (o_resp),
      .o_rd_valid       (w_rd_valid),
      .o_rd_addr        (w_rd_addr),
      .i_rd_hit         (w_rd_hit),
      .i_rd_data        (w_rd_data),
      .o_sb_push        (w_sb_push),
      .o_sb_entry       (w_sb_entry),
      .o_sb_search_addr (w_sb_search_addr),
      .i_sb_search      (w_sb_search),
      .i_sb_full        (w_sb_full),
      .i_sb_empty       (w_sb_empty),
      .o_miss_start     (w_miss_start),
      .o_miss_addr      (w_miss_addr),
      .i_miss_done      (w_miss_done)
   );

   lsu_dcache #(
      .NUM_SETS (NUM_SETS)
   ) u_dcache (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_rd_valid    (w_rd_valid),
      .i_rd_addr     (w_rd_addr),
      .o_rd_hit      (w_rd_hit),
      .o_rd_data     (w_rd_data),
      .i_snp_valid   (i_snoop_valid),
      .i_snp_addr    (i_snoop_addr),
      .o_snp_hit     (w_snp_hit),
      .o_snp_data    (w_snp_data),
      .i_refill_we   (w_refill_we),
      .i_refill_addr (w_refill_addr),
      .i_refill_data (w_refill_data),
      .i_refill_last (w_refill_last),
      .i_upd_we      (w_upd_we),
      .i_upd_addr    (w_upd_addr),
      .i_upd_data    (w_upd_data)
   );

   lsu_miss_unit u_miss_unit (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_start       (w_miss_start),
      .i_addr        (w_miss_addr),
      .o_done        (w_miss_done),
      .o_mreq        (w_miss_mreq),
      .o_mcmd        (w_miss_mcmd),
      .i_mack        (w_miss_mack),
      .i_mrdata      (i_mem_rdata),
      .o_refill_we   (w_refill_we),
      .o_refill_addr (w_refill_addr),
      .o_refill_data (w_refill_data),
      .o_refill_last (w_refill_last)
   );

   lsu_store_buffer #(
      .SB_DEPTH (SB_DEPTH)
   ) u_store_buffer (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_push        (w_sb_push),
      .i_entry       (w_sb_entry),
      .i_search_addr (w_sb_search_addr),
      .o_search      (w_sb_search),
      .o_full        (w_sb_full),
      .o_empty       (w_sb_empty),
      .o_mreq        (w_sb_mreq),
      .o_mcmd        (w_sb_mcmd),
      .i_mack        (w_sb_mack),
      .o_upd_we      (w_upd_we),
      .o_upd_addr    (w_upd_addr),
      .o_upd_data    (w_upd_data)
   );

   // Miss unit on client 0 so refills go first
   lsu_mem_arbiter u_mem_arbiter (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_req0    (w_miss_mreq),
      .i_cmd0    (w_miss_mcmd),
      .o_ack0    (w_miss_mack),
      .i_req1    (w_sb_mreq),
      .i_cmd1    (w_sb_mcmd),
      .o_ack1    (w_sb_mack),
      .o_mem_req (o_mem_req),
      .o_mem_cmd (o_mem_cmd),
      .i_mem_ack (i_mem_ack)
   );

   // --------------------
   // Snoop response
   // --------------------
   logic r_snoop_resp_valid;

   always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_snoop_resp_valid <= 1'b0;
      end else begin
         r_snoop_resp_valid <= i_snoop_valid;
      end
   end

   // Hit and data come registered from the cache snoop port
   assign o_snoop_resp_valid = r_snoop_resp_valid;
   assign o_snoop_resp       = '{hit: w_snp_hit, data: w_snp_data};

endmodule

// ==== tb_mem_responder.sv ====
// External memory model for the testbench
// Answers four-phase requests after a random delay
// Memory initialised to an address-derived pattern

`timescale 1ns/1ps

module tb_mem_responder
   import lsu_pkg::*;
#(
   parameter int SEED = 79
) (
   input  logic     i_clk,
   input  logic     i_reset_n,
   input  logic     i_req,
   input  mem_cmd_t i_cmd,
   output logic     o_ack,
   output word_t    o_rdata
);

   word_t      mem [0:65535];
   int         seed = SEED;
   logic [2:0] r_wait;
   logic       r_busy;

   initial begin
      for (int i = 0; i < 65536; i++) begin
         mem[i] = {16'(i) ^ 16'ha5c3, 16'(i)};
      end
   end

   always @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         o_ack   <= 1'b0;
         o_rdata <= '0;
         r_wait  <= '0;
         r_busy  <= 1'b0;
      end else if (!o_ack && i_req) begin
         if (!r_busy) begin
            // Extra delay of 0 to 5 cycles
            r_busy <= 1'b1;
            r_wait <= 3'($unsigned($random(seed)) % 6);
         end else if (r_wait == '0) begin
            o_ack   <= 1'b1;
            o_rdata <= mem[i_cmd.addr];
            r_busy  <= 1'b0;
         end else begin
            r_wait <= r_wait - 1'b1;
         end
      end else if (o_ack && i_req) begin
         // Write lands on the same edge as the cache update
         if (i_cmd.write) begin
            mem[i_cmd.addr] <= i_cmd.data;
         end
      end else if (o_ack && !i_req) begin
         o_ack <= 1'b0;
      end
   end

endmodule

// ==== tb_lsu_top.sv ====
// Testbench for the load/store unit
// Random loads, stores and snoops against a word-array model
// Checks load results, write-through, snoops and the memory handshake

`timescale 1ns/1ps

module tb_lsu_top;
   import lsu_pkg::*;

   localparam int NUM_REQS   = 2000;
   localparam int MAX_CYCLES = NUM_REQS * 40;

   logic        i_clk;
   logic        i_reset_n;
   logic        i_req_valid;
   lsu_req_t    i_req;
   logic        o_req_ready;
   logic        o_resp_valid;
   lsu_resp_t   o_resp;
   logic        i_snoop_valid;
   addr_t       i_snoop_addr;
   logic        o_snoop_resp_valid;
   snoop_resp_t o_snoop_resp;
   logic        o_mem_req;
   mem_cmd_t    o_mem_cmd;
   logic        i_mem_ack;
   word_t       i_mem_rdata;

   int          seed = 79;
   int          cycles;
   word_t       model [0:65535];
   lsu_resp_t   exp_q [$];
   lsu_resp_t   exp_resp;
   lsu_req_t    req;
   addr_t       last_store_addr;
   logic        have_store;
   logic        accepted;
   logic [31:0] r;
   logic [31:0] r_snp;
   logic        snp_pending;
   word_t       snp_exp_data;
   int          snp_hits;
   int          snp_misses;
   logic        prev_req;
   mem_cmd_t    prev_cmd;

   lsu_top UUT (.*);

   tb_mem_responder #(.SEED(79)) u_mem (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_req     (o_mem_req),
      .i_cmd     (o_mem_cmd),
      .o_ack     (i_mem_ack),
      .o_rdata   (i_mem_rdata)
   );

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   // --------------------
   // Helpers
   // --------------------
   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "stopping");
   endtask

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
         stop_with_failure("value mismatch");
      end
   endtask

   // Two 32-word regions that map onto the same sets
   function automatic addr_t window_addr(input logic [5:0] sel);
      return (sel[5] ? 16'h1000 : 16'h0000) + {11'b0, sel[4:0]};
   endfunction

   task automatic make_request(output lsu_req_t q);
      logic [31:0] v;
      v = $random(seed);
      q.op   = (v[3:0] < 4'd6) ? OP_STORE : OP_LOAD;
      q.addr = window_addr(v[13:8]);
      // Often revisit the last store to exercise forwarding
      if (have_store && v[7:6] == 2'b00) begin
         q.addr = last_store_addr;
      end
      q.data = $random(seed);
   endtask

   // --------------------
   // Main stimulus
   // --------------------
   initial begin
      i_reset_n     = 1'b0;
      i_req_valid   = 1'b0;
      i_req         = '0;
      i_snoop_valid = 1'b0;
      i_snoop_addr  = '0;
      have_store    = 1'b0;
      snp_hits      = 0;
      snp_misses    = 0;
      repeat (8) @(posedge i_clk);
      i_reset_n <= 1'b1;
      @(negedge i_clk);
      for (int i = 0; i < 65536; i++) begin
         model[i] = u_mem.mem[i];
      end
      for (int n = 0; n < NUM_REQS; n++) begin
         make_request(req);
         r = $random(seed);
         @(posedge i_clk);
         if (r[2:0] == 3'd0) begin
            i_req_valid <= 1'b0;
            @(posedge i_clk);
         end
         i_req_valid <= 1'b1;
         i_req       <= req;
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge i_clk);
            accepted = o_req_ready;
         end
         // Accepted on the coming edge, model follows program order
         if (req.op == OP_STORE) begin
            model[req.addr] = req.data;
            last_store_addr = req.addr;
            have_store      = 1'b1;
         end else begin
            exp_q.push_back('{data: model[req.addr], addr: req.addr});
         end
      end
      @(posedge i_clk);
      i_req_valid <= 1'b0;
      while (exp_q.size() != 0) @(negedge i_clk);
      // Wait for the store buffer to drain
      while (!UUT.u_store_buffer.o_empty || o_mem_req || i_mem_ack) @(negedge i_clk);
      for (int i = 0; i < 64; i++) begin
         compare_word("memory word", u_mem.mem[window_addr(6'(i))],
                      model[window_addr(6'(i))]);
      end
      repeat (4) @(negedge i_clk);
      if ((snp_hits == 0) || (snp_misses == 0)) begin
         stop_with_failure("snoop port never reported both a hit and a miss");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

   // Snoop traffic
   initial begin
      @(posedge i_reset_n);
      forever begin
         @(posedge i_clk);
         r_snp = $random(seed);
         i_snoop_valid <= (r_snp[1:0] == 2'b00);
         i_snoop_addr  <= window_addr(r_snp[13:8]);
      end
   end

   // --------------------
   // Monitors
   // --------------------
   always @(negedge i_clk) begin
      if (i_reset_n) begin
         if (o_resp_valid) begin
            if (exp_q.size() == 0) begin
               stop_with_failure("load result arrived with no load outstanding");
            end
            exp_resp = exp_q.pop_front();
            compare_word("o_resp.addr", 32'(o_resp.addr), 32'(exp_resp.addr));
            compare_word("o_resp.data", o_resp.data, exp_resp.data);
         end
         compare_word("o_snoop_resp_valid", 32'(o_snoop_resp_valid), 32'(snp_pending));
         if (snp_pending) begin
            if (o_snoop_resp.hit) begin
               snp_hits = snp_hits + 1;
               compare_word("o_snoop_resp.data", o_snoop_resp.data, snp_exp_data);
            end else begin
               snp_misses = snp_misses + 1;
            end
         end
         snp_pending  = i_snoop_valid;
         snp_exp_data = u_mem.mem[i_snoop_addr];
         // Four-phase rules on the memory port
         if (o_mem_req && !prev_req && i_mem_ack) begin
            stop_with_failure("memory req raised while ack was still high");
         end
         if (o_mem_req && prev_req && (o_mem_cmd != prev_cmd)) begin
            stop_with_failure("memory command changed while req was high");
         end
         prev_req = o_mem_req;
         prev_cmd = o_mem_cmd;
      end else begin
         snp_pending = 1'b0;
         prev_req    = 1'b0;
      end
   end

   // Run length limit
   always @(posedge i_clk) begin
      if (!i_reset_n) begin
         cycles <= 0;
      end else begin
         cycles <= cycles + 1;
         if (cycles > MAX_CYCLES) begin
            stop_with_failure("timeout: the test did not finish in time");
         end
      end
   end

endmodule

// ==== flist.f ====
lsu_pkg.sv
lsu_pipe.sv
lsu_dcache.sv
lsu_miss_unit.sv
lsu_store_buffer.sv
lsu_mem_arbiter.sv
lsu_top.sv
tb_mem_responder.sv
tb_lsu_top.sv

// ==== Makefile ====
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
